/* logic/alut_pkg.sv */
// register map, command codes, table sizes and table entry type for the address lookup unit
package alut_pkg;

   // ------------------------------------------------------------
   // apb register map, byte addresses
   // ------------------------------------------------------------
   localparam logic [6:0] al_frm_d_addr_l   = 7'h00; // dest mac, low word
   localparam logic [6:0] al_frm_d_addr_u   = 7'h04; // dest mac, upper 16
   localparam logic [6:0] al_frm_s_addr_l   = 7'h08;
   localparam logic [6:0] al_frm_s_addr_u   = 7'h0C;
   localparam logic [6:0] al_s_port         = 7'h10; // source port of frame
   localparam logic [6:0] al_d_port         = 7'h14; // read only, one-hot result
   localparam logic [6:0] al_mac_addr_l     = 7'h18; // own switch address
   localparam logic [6:0] al_mac_addr_u     = 7'h1C;
   localparam logic [6:0] al_cur_time       = 7'h20; // read only
   localparam logic [6:0] al_bb_age         = 7'h24; // best-before age
   localparam logic [6:0] al_div_clk        = 7'h28; // time prescaler
   localparam logic [6:0] al_status         = 7'h2C; // reused, inval, active
   localparam logic [6:0] al_lst_inv_addr_l = 7'h30;
   localparam logic [6:0] al_lst_inv_addr_u = 7'h34;
   localparam logic [6:0] al_lst_inv_port   = 7'h38;
   localparam logic [6:0] al_command        = 7'h3C; // self clearing

   // command codes
   localparam logic [1:0] cmd_age   = 2'd1; // sweep table for stale entries
   localparam logic [1:0] cmd_check = 2'd2; // lookup dest, learn source

   // learning table geometry, direct mapped on addr[2:0]
   localparam int tbl_entries = 8;
   localparam int tbl_idx_w   = 3;
   localparam logic [tbl_idx_w-1:0] tbl_last = tbl_idx_w'(tbl_entries - 1);

   // one table word, 83 bits
   typedef struct packed {
      logic        valid;
      logic [47:0] addr;  // learned mac
      logic [1:0]  port;  // port it was seen on
      logic [31:0] stamp; // curr_time when learned
   } tbl_entry_t;

endpackage

/* logic/alut_mem_if.sv */
// four-phase req/ack table port with requester and table modports
`timescale 1ns/10ps

interface alut_mem_if;

   logic                             req;   // held until ack seen
   logic                             ack;   // served with rdata valid
   logic                             we;    // write wdata at idx
   logic [alut_pkg::tbl_idx_w-1:0]   idx;   // table index
   alut_pkg::tbl_entry_t             wdata;
   alut_pkg::tbl_entry_t             rdata; // old word at idx

   // checker side
   modport requester (
      output req,
      output we,
      output idx,
      output wdata,
      input  ack,
      input  rdata
   );

   // table side
   modport tbl (
      input  req,
      input  we,
      input  idx,
      input  wdata,
      output ack,
      output rdata
   );

endinterface

/* logic/alut_reg_bank.sv */
// apb register bank with read mux, self-clearing command and last-invalidated capture
`timescale 1ns/10ps

module alut_reg_bank (
   input  logic        pclk14,
   input  logic        n_p_reset14,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [6:0]  paddr,
   input  logic [31:0] pwdata,
   input  logic [31:0] curr_time,        // from age checker
   input  logic        active,           // address check running
   input  logic        inval_in_prog,    // age sweep running
   input  logic        reused,           // sticky, from address checker
   input  logic [4:0]  d_port,
   input  logic [47:0] lst_inv_addr_nrm,
   input  logic [1:0]  lst_inv_port_nrm,
   input  logic        nrm_inv,
   input  logic [47:0] lst_inv_addr_cmd,
   input  logic [1:0]  lst_inv_port_cmd,
   input  logic        cmd_inv,
   output logic [31:0] prdata,
   output logic [47:0] mac_addr,
   output logic [47:0] d_addr,
   output logic [47:0] s_addr,
   output logic [1:0]  s_port,
   output logic [31:0] best_bfr_age,
   output logic [7:0]  div_clk,
   output logic [1:0]  command,
   output logic        clear_reused
);

   logic        read_enable;  // setup phase of a read
   logic        write_enable; // access phase of a write
   logic [47:0] lst_inv_addr;
   logic [1:0]  lst_inv_port;

   assign read_enable  = psel & ~penable & ~pwrite;
   assign write_enable = psel & penable & pwrite;

   // reading status while idle acknowledges the reused flag
   assign clear_reused = read_enable & (paddr == alut_pkg::al_status) & ~active;

   // ------------------------------------------------------------
   // read mux, registered in setup phase
   // ------------------------------------------------------------
   always_ff @(posedge pclk14 or negedge n_p_reset14)
      if (!n_p_reset14)
         prdata <= '0;
      else if (read_enable)
      begin
         case (paddr)
            alut_pkg::al_frm_d_addr_l   : prdata <= d_addr[31:0];
            alut_pkg::al_frm_d_addr_u   : prdata <= {16'd0, d_addr[47:32]};
            alut_pkg::al_frm_s_addr_l   : prdata <= s_addr[31:0];
            alut_pkg::al_frm_s_addr_u   : prdata <= {16'd0, s_addr[47:32]};
            alut_pkg::al_s_port         : prdata <= {30'd0, s_port};
            alut_pkg::al_d_port         : prdata <= {27'd0, d_port};
            alut_pkg::al_mac_addr_l     : prdata <= mac_addr[31:0];
            alut_pkg::al_mac_addr_u     : prdata <= {16'd0, mac_addr[47:32]};
            alut_pkg::al_cur_time       : prdata <= curr_time;
            alut_pkg::al_bb_age         : prdata <= best_bfr_age;
            alut_pkg::al_div_clk        : prdata <= {24'd0, div_clk};
            alut_pkg::al_status         : prdata <= {29'd0, reused, inval_in_prog, active};
            alut_pkg::al_lst_inv_addr_l : prdata <= lst_inv_addr[31:0];
            alut_pkg::al_lst_inv_addr_u : prdata <= {16'd0, lst_inv_addr[47:32]};
            alut_pkg::al_lst_inv_port   : prdata <= {30'd0, lst_inv_port};
            default                     : prdata <= '0; // holes and command
         endcase
      end
      else
         prdata <= '0; // bus idle outside reads

   // ------------------------------------------------------------
   // writable registers
   // ------------------------------------------------------------
   always_ff @(posedge pclk14 or negedge n_p_reset14)
      if (!n_p_reset14)
      begin
         d_addr       <= '0;
         s_addr       <= '0;
         s_port       <= '0;
         mac_addr     <= '0;
         best_bfr_age <= '1; // nothing ages by default
         div_clk      <= '0;
      end
      else if (write_enable)
      begin
         case (paddr)
            alut_pkg::al_frm_d_addr_l : d_addr[31:0]    <= pwdata;
            alut_pkg::al_frm_d_addr_u : d_addr[47:32]   <= pwdata[15:0];
            alut_pkg::al_frm_s_addr_l : s_addr[31:0]    <= pwdata;
            alut_pkg::al_frm_s_addr_u : s_addr[47:32]   <= pwdata[15:0];
            alut_pkg::al_s_port       : s_port          <= pwdata[1:0];
            alut_pkg::al_mac_addr_l   : mac_addr[31:0]  <= pwdata;
            alut_pkg::al_mac_addr_u   : mac_addr[47:32] <= pwdata[15:0];
            alut_pkg::al_bb_age       : best_bfr_age    <= pwdata;
            alut_pkg::al_div_clk      : div_clk         <= pwdata[7:0];
            default                   : ;
         endcase
      end

   // command lives for a single cycle
   always_ff @(posedge pclk14 or negedge n_p_reset14)
      if (!n_p_reset14)
         command <= '0;
      else if (command != 2'b00)
         command <= '0;
      else if (write_enable && paddr == alut_pkg::al_command)
         command <= pwdata[1:0];

   // ------------------------------------------------------------
   // last invalidated entry, learning overwrite wins over aging
   // ------------------------------------------------------------
   always_ff @(posedge pclk14 or negedge n_p_reset14)
      if (!n_p_reset14)
      begin
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if (nrm_inv)
      begin
         lst_inv_addr <= lst_inv_addr_nrm;
         lst_inv_port <= lst_inv_port_nrm;
      end
      else if (cmd_inv)
      begin
         lst_inv_addr <= lst_inv_addr_cmd;
         lst_inv_port <= lst_inv_port_cmd;
      end

   a_no_rd_wr : assert property (@(posedge pclk14) disable iff (!n_p_reset14)
      !(read_enable && write_enable));

   // checkers rely on a one-cycle command strobe
   a_cmd_pulse : assert property (@(posedge pclk14) disable iff (!n_p_reset14)
      command != 2'b00 |=> command == 2'b00);

endmodule

/* logic/alut_addr_checker.sv */
// destination lookup, source learning and sticky reused flag
`timescale 1ns/10ps

module alut_addr_checker (
   input  logic        pclk14,
   input  logic        n_p_reset14,
   input  logic [1:0]  command,
   input  logic [47:0] d_addr,
   input  logic [47:0] s_addr,
   input  logic [1:0]  s_port,
   input  logic [47:0] mac_addr,
   input  logic [31:0] curr_time,
   input  logic        clear_reused,
   output logic [4:0]  d_port,
   output logic        active,
   output logic        reused,
   output logic [47:0] lst_inv_addr_nrm,
   output logic [1:0]  lst_inv_port_nrm,
   output logic        nrm_inv,
   alut_mem_if.requester chk_if
);

   logic [2:0] step;        // 0 idle, 1 dest read, 2 gap, 3 source swap, 4 release
   logic [4:0] lookup_port; // port decision from the dest entry

   // ------------------------------------------------------------
   // port decision
   // ------------------------------------------------------------
   always_comb
      if (d_addr == mac_addr)
         lookup_port = 5'b10000; // frame for the switch itself
      else if (chk_if.rdata.valid && chk_if.rdata.addr == d_addr)
         lookup_port = 5'b00001 << chk_if.rdata.port;
      else
         lookup_port = {1'b0, ~(4'b0001 << s_port)}; // flood, skip source

   // ------------------------------------------------------------
   // check sequencer, two table transactions
   // ------------------------------------------------------------
   always_ff @(posedge pclk14 or negedge n_p_reset14)
      if (!n_p_reset14)
      begin
         step             <= 3'd0;
         active           <= 1'b0;
         reused           <= 1'b0;
         nrm_inv          <= 1'b0;
         d_port           <= '0;
         lst_inv_addr_nrm <= '0;
         lst_inv_port_nrm <= '0;
         chk_if.req       <= 1'b0;
         chk_if.we        <= 1'b0;
         chk_if.idx       <= '0;
         chk_if.wdata     <= '0;
      end
      else
      begin
         nrm_inv <= 1'b0;
         if (clear_reused)
            reused <= 1'b0;
         case (step)
            3'd0 :
               if (command == alut_pkg::cmd_check)
               begin
                  active     <= 1'b1;
                  chk_if.req <= 1'b1;
                  chk_if.we  <= 1'b0;
                  chk_if.idx <= d_addr[alut_pkg::tbl_idx_w-1:0];
                  step       <= 3'd1;
               end
            3'd1 :
               if (chk_if.ack)
               begin
                  d_port     <= lookup_port;
                  chk_if.req <= 1'b0;
                  step       <= 3'd2;
               end
            3'd2 :
               if (!chk_if.ack) // wait out phase four
               begin
                  chk_if.req   <= 1'b1;
                  chk_if.we    <= 1'b1;
                  chk_if.idx   <= s_addr[alut_pkg::tbl_idx_w-1:0];
                  chk_if.wdata <= {1'b1, s_addr, s_port, curr_time}; // stamp now
                  step         <= 3'd3;
               end
            3'd3 :
               if (chk_if.ack)
               begin
                  // rdata holds the word that was just replaced
                  if (chk_if.rdata.valid && chk_if.rdata.addr != s_addr)
                  begin
                     nrm_inv          <= 1'b1;
                     reused           <= 1'b1;
                     lst_inv_addr_nrm <= chk_if.rdata.addr;
                     lst_inv_port_nrm <= chk_if.rdata.port;
                  end
                  chk_if.req <= 1'b0;
                  step       <= 3'd4;
               end
            default :
               if (!chk_if.ack)
               begin
                  active <= 1'b0;
                  step   <= 3'd0;
               end
         endcase
      end

   a_req_hold : assert property (@(posedge pclk14) disable iff (!n_p_reset14)
      $fell(chk_if.req) |-> chk_if.ack);

endmodule

/* logic/alut_age_checker.sv */
// time counter with prescaler and aging sweep of the learning table
`timescale 1ns/10ps

module alut_age_checker (
   input  logic        pclk14,
   input  logic        n_p_reset14,
   input  logic [1:0]  command,
   input  logic [31:0] best_bfr_age,
   input  logic [7:0]  div_clk,
   output logic [31:0] curr_time,
   output logic        inval_in_prog,
   output logic [47:0] lst_inv_addr_cmd,
   output logic [1:0]  lst_inv_port_cmd,
   output logic        cmd_inv,
   alut_mem_if.requester age_if
);

   logic [7:0]           div_cnt; // prescaler
   logic [2:0]           step;    // 0 idle, 1 read, 2 decide, 3 write, 4 release, 5 advance
   alut_pkg::tbl_entry_t ent;     // entry under test
   logic                 aged;

   // age with wrap of the time counter
   assign aged = ent.valid && (curr_time - ent.stamp) > best_bfr_age;

   // ------------------------------------------------------------
   // time base, one tick every div_clk+1 cycles
   // ------------------------------------------------------------
   always_ff @(posedge pclk14 or negedge n_p_reset14)
      if (!n_p_reset14)
      begin
         div_cnt   <= '0;
         curr_time <= '0;
      end
      else if (div_cnt >= div_clk)
      begin
         div_cnt   <= '0;
         curr_time <= curr_time + 32'd1;
      end
      else
         div_cnt <= div_cnt + 8'd1;

   // ------------------------------------------------------------
   // aging sweep over all entries
   // ------------------------------------------------------------
   always_ff @(posedge pclk14 or negedge n_p_reset14)
      if (!n_p_reset14)
      begin
         step             <= 3'd0;
         inval_in_prog    <= 1'b0;
         cmd_inv          <= 1'b0;
         ent              <= '0;
         lst_inv_addr_cmd <= '0;
         lst_inv_port_cmd <= '0;
         age_if.req       <= 1'b0;
         age_if.we        <= 1'b0;
         age_if.idx       <= '0;
         age_if.wdata     <= '0;
      end
      else
      begin
         cmd_inv <= 1'b0;
         case (step)
            3'd0 :
               if (command == alut_pkg::cmd_age)
               begin
                  inval_in_prog <= 1'b1;
                  age_if.req    <= 1'b1;
                  age_if.we     <= 1'b0;
                  age_if.idx    <= '0;
                  step          <= 3'd1;
               end
            3'd1 :
               if (age_if.ack)
               begin
                  ent        <= age_if.rdata;
                  age_if.req <= 1'b0;
                  step       <= 3'd2;
               end
            3'd2 :
               if (!age_if.ack)
                  if (aged)
                  begin
                     age_if.req   <= 1'b1;
                     age_if.we    <= 1'b1;
                     age_if.wdata <= {1'b0, ent.addr, ent.port, ent.stamp}; // drop valid
                     step         <= 3'd3;
                  end
                  else
                     step <= 3'd5;
            3'd3 :
               if (age_if.ack)
               begin
                  cmd_inv          <= 1'b1;
                  lst_inv_addr_cmd <= ent.addr;
                  lst_inv_port_cmd <= ent.port;
                  age_if.req       <= 1'b0;
                  step             <= 3'd4;
               end
            3'd4 :
               if (!age_if.ack)
                  step <= 3'd5;
            default :
               if (age_if.idx == alut_pkg::tbl_last)
               begin
                  inval_in_prog <= 1'b0; // sweep done
                  step          <= 3'd0;
               end
               else
               begin
                  age_if.idx <= age_if.idx + 1'b1;
                  age_if.req <= 1'b1;
                  age_if.we  <= 1'b0;
                  step       <= 3'd1;
               end
         endcase
      end

   a_req_hold : assert property (@(posedge pclk14) disable iff (!n_p_reset14)
      $fell(age_if.req) |-> age_if.ack);

endmodule

/* logic/alut_mem.sv */
// eight-entry learning table with two-port four-phase arbiter
`timescale 1ns/10ps

module alut_mem (
   input  logic pclk14,
   input  logic n_p_reset14,
   alut_mem_if.tbl chk_if,
   alut_mem_if.tbl age_if
);

   alut_pkg::tbl_entry_t             mem [alut_pkg::tbl_entries];
   alut_pkg::tbl_entry_t             rdata_q;
   alut_pkg::tbl_entry_t             wdata_g;
   logic [alut_pkg::tbl_idx_w-1:0]   idx_g;
   logic                             we_g;
   logic                             grant_chk; // address checker has priority
   logic                             grant_age;

   // new grant only while no handshake is open
   assign grant_chk = chk_if.req & ~chk_if.ack & ~age_if.ack;
   assign grant_age = age_if.req & ~age_if.ack & ~chk_if.ack & ~chk_if.req;

   assign idx_g   = grant_chk ? chk_if.idx   : age_if.idx;
   assign we_g    = grant_chk ? chk_if.we    : age_if.we;
   assign wdata_g = grant_chk ? chk_if.wdata : age_if.wdata;

   // only the acked side looks at rdata
   assign chk_if.rdata = rdata_q;
   assign age_if.rdata = rdata_q;

   // ------------------------------------------------------------
   // acks held until req drops
   // ------------------------------------------------------------
   always_ff @(posedge pclk14 or negedge n_p_reset14)
      if (!n_p_reset14)
      begin
         chk_if.ack <= 1'b0;
         age_if.ack <= 1'b0;
      end
      else
      begin
         if (grant_chk)
            chk_if.ack <= 1'b1;
         else if (!chk_if.req)
            chk_if.ack <= 1'b0;
         if (grant_age)
            age_if.ack <= 1'b1;
         else if (!age_if.req)
            age_if.ack <= 1'b0;
      end

   // storage returning the old word on a write
   always_ff @(posedge pclk14 or negedge n_p_reset14)
      if (!n_p_reset14)
      begin
         for (int i = 0; i < alut_pkg::tbl_entries; i++)
            mem[i] <= '0; // all invalid
         rdata_q <= '0;
      end
      else if (grant_chk || grant_age)
      begin
         rdata_q <= mem[idx_g];
         if (we_g)
            mem[idx_g] <= wdata_g;
      end

   // requester still holds req when its ack shows up
   a_chk_ack : assert property (@(posedge pclk14) disable iff (!n_p_reset14)
      $rose(chk_if.ack) |-> chk_if.req);
   a_age_ack : assert property (@(posedge pclk14) disable iff (!n_p_reset14)
      $rose(age_if.ack) |-> age_if.req);

endmodule

/* logic/alut.sv */
// address lookup unit top level with apb ports
`timescale 1ns/10ps

module alut (
   input  logic        pclk14,
   input  logic        n_p_reset14,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [6:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata
);

   // reg bank to checkers
   logic [1:0]  command;
   logic [47:0] d_addr;
   logic [47:0] s_addr;
   logic [47:0] mac_addr;
   logic [1:0]  s_port;
   logic [31:0] best_bfr_age;
   logic [7:0]  div_clk;
   logic        clear_reused;

   // checkers to reg bank
   logic [4:0]  d_port;
   logic        active;
   logic        reused;
   logic [31:0] curr_time;
   logic        inval_in_prog;
   logic [47:0] lst_inv_addr_nrm;
   logic [1:0]  lst_inv_port_nrm;
   logic        nrm_inv;
   logic [47:0] lst_inv_addr_cmd;
   logic [1:0]  lst_inv_port_cmd;
   logic        cmd_inv;

   // one table port per checker
   alut_mem_if chk_if ();
   alut_mem_if age_if ();

   alut_reg_bank     i_reg_bank (.*);
   alut_addr_checker i_addr_checker (.*);
   alut_age_checker  i_age_checker (.*);
   alut_mem          i_mem (.*);

endmodule

/* verification/alut_tb.sv */
// testbench for the address lookup unit with apb tasks, reference model and step table
`timescale 1ns/10ps

module alut_tb;

   logic        pclk14;
   logic        n_p_reset14;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [6:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;

   typedef enum logic [1:0] {step_write, step_read, step_poll, step_time} step_kind_t;

   step_kind_t  step_kind [$]; // stimulus table
   logic [6:0]  step_addr [$];
   logic [31:0] step_data [$]; // write data or expected read value

   int          cycle_budget  = 0;
   int          cycle_limit   = 1000; // raised once the table is built
   int          cycle_count   = 0;
   int          checks        = 0;
   int          read_errors   = 0;
   int          status_errors = 0;
   logic [31:0] lcg_state     = 32'h8186_d205;

   // reference model of the learning table
   logic        ref_valid [8];
   logic [47:0] ref_addr [8];
   logic [1:0]  ref_port [8];
   logic [47:0] ref_mac;
   logic [47:0] ref_lst_addr;
   logic [1:0]  ref_lst_port;

   alut alut_inst (.*);

   always #5 pclk14 = ~pclk14; // 10 ns period

   // ------------------------------------------------------------
   // random source and reference model
   // ------------------------------------------------------------
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // random mac landing on a chosen table index
   function automatic logic [47:0] make_addr(input logic [2:0] idx);
      logic [31:0] hi;
      logic [31:0] lo;
      hi = lcg_next();
      lo = lcg_next();
      return {hi[15:0], lo[31:3], idx};
   endfunction

   function automatic logic [4:0] expected_port(input logic [47:0] d, input logic [1:0] sp);
      if (d == ref_mac)
         return 5'b10000; // own address
      if (ref_valid[d[2:0]] && ref_addr[d[2:0]] == d)
         return 5'b00001 << ref_port[d[2:0]]; // known destination
      return 5'b01111 & ~(5'b00001 << sp); // flood all ports but the source
   endfunction

   // returns 1 when a different valid address was pushed out
   function automatic bit learn_source(input logic [47:0] s, input logic [1:0] sp);
      bit replaced;
      replaced = ref_valid[s[2:0]] && ref_addr[s[2:0]] != s;
      if (replaced)
      begin
         ref_lst_addr = ref_addr[s[2:0]];
         ref_lst_port = ref_port[s[2:0]];
      end
      ref_valid[s[2:0]] = 1'b1;
      ref_addr[s[2:0]]  = s;
      ref_port[s[2:0]]  = sp;
      return replaced;
   endfunction

   // best-before zero ages every valid entry and the highest index is captured last
   function automatic void age_all();
      for (int i = 0; i < alut_pkg::tbl_entries; i++)
         if (ref_valid[i])
         begin
            ref_lst_addr = ref_addr[i];
            ref_lst_port = ref_port[i];
            ref_valid[i] = 1'b0;
         end
   endfunction

   // ------------------------------------------------------------
   // table construction
   // ------------------------------------------------------------
   task automatic push_step(input step_kind_t kind, input logic [6:0] addr,
                            input logic [31:0] data);
      step_kind.push_back(kind);
      step_addr.push_back(addr);
      step_data.push_back(data);
      cycle_budget += (kind == step_poll) ? 150 : 3; // poll covers a full sweep
   endtask

   task automatic readback_pair(input logic [6:0] addr, input logic [31:0] mask);
      logic [31:0] pattern;
      pattern = lcg_next();
      push_step(step_write, addr, pattern);
      push_step(step_read, addr, pattern & mask); // unused bits read zero
   endtask

   task automatic check_sequence(input logic [47:0] d, input logic [47:0] s,
                                 input logic [1:0] sp);
      logic [4:0] exp_port;
      bit         reuse;
      exp_port = expected_port(d, sp); // lookup precedes learning
      reuse    = learn_source(s, sp);
      push_step(step_write, alut_pkg::al_frm_d_addr_l, d[31:0]);
      push_step(step_write, alut_pkg::al_frm_d_addr_u, {16'd0, d[47:32]});
      push_step(step_write, alut_pkg::al_frm_s_addr_l, s[31:0]);
      push_step(step_write, alut_pkg::al_frm_s_addr_u, {16'd0, s[47:32]});
      push_step(step_write, alut_pkg::al_s_port, {30'd0, sp});
      push_step(step_write, alut_pkg::al_command, {30'd0, alut_pkg::cmd_check});
      push_step(step_poll, alut_pkg::al_status, reuse ? 32'h4 : 32'h0);
      push_step(step_read, alut_pkg::al_d_port, {27'd0, exp_port});
   endtask

   task automatic age_sweep(input logic [31:0] bb_age);
      push_step(step_write, alut_pkg::al_bb_age, bb_age);
      push_step(step_write, alut_pkg::al_command, {30'd0, alut_pkg::cmd_age});
      push_step(step_poll, alut_pkg::al_status, 32'h0);
      if (bb_age == 32'h0)
         age_all(); // all ones ages nothing
   endtask

   task automatic last_inv_reads();
      push_step(step_read, alut_pkg::al_lst_inv_addr_l, ref_lst_addr[31:0]);
      push_step(step_read, alut_pkg::al_lst_inv_addr_u, {16'd0, ref_lst_addr[47:32]});
      push_step(step_read, alut_pkg::al_lst_inv_port, {30'd0, ref_lst_port});
   endtask

   task automatic build_steps();
      logic [47:0] a_addr;
      logic [47:0] b_addr;
      logic [47:0] c_addr;
      logic [47:0] e_addr;
      for (int i = 0; i < alut_pkg::tbl_entries; i++)
         ref_valid[i] = 1'b0;
      ref_mac      = '0;
      ref_lst_addr = '0;
      ref_lst_port = '0;
      // reset values over the whole map including holes
      for (int a = 0; a < 128; a += 4)
         if (7'(a) != alut_pkg::al_cur_time)
            push_step(step_read, 7'(a),
                      (7'(a) == alut_pkg::al_bb_age) ? 32'hFFFF_FFFF : 32'h0);
      readback_pair(alut_pkg::al_frm_d_addr_l, 32'hFFFF_FFFF);
      readback_pair(alut_pkg::al_frm_d_addr_u, 32'h0000_FFFF);
      readback_pair(alut_pkg::al_frm_s_addr_l, 32'hFFFF_FFFF);
      readback_pair(alut_pkg::al_frm_s_addr_u, 32'h0000_FFFF);
      readback_pair(alut_pkg::al_s_port, 32'h0000_0003);
      readback_pair(alut_pkg::al_mac_addr_l, 32'hFFFF_FFFF);
      readback_pair(alut_pkg::al_mac_addr_u, 32'h0000_FFFF);
      readback_pair(alut_pkg::al_bb_age, 32'hFFFF_FFFF);
      readback_pair(alut_pkg::al_div_clk, 32'h0000_00FF);
      push_step(step_write, alut_pkg::al_bb_age, 32'hFFFF_FFFF); // back to defaults
      push_step(step_write, alut_pkg::al_div_clk, 32'h0);
      ref_mac = make_addr(3'd7); // own address parked on index 7
      push_step(step_write, alut_pkg::al_mac_addr_l, ref_mac[31:0]);
      push_step(step_write, alut_pkg::al_mac_addr_u, {16'd0, ref_mac[47:32]});
      a_addr = make_addr(3'd3);
      b_addr = make_addr(3'd3); // collides with a
      c_addr = make_addr(3'd1);
      e_addr = make_addr(3'd1); // fresh source for the aged index of c
      // learn then look up
      check_sequence(make_addr(3'd5), a_addr, 2'd2);
      check_sequence(a_addr, c_addr, 2'd0);
      // unknown and own destination
      check_sequence(make_addr(3'd4), c_addr, 2'd0);
      check_sequence(ref_mac, c_addr, 2'd0);
      // reuse of index 3
      check_sequence(c_addr, b_addr, 2'd3);
      push_step(step_read, alut_pkg::al_status, 32'h0); // sticky flag gone
      last_inv_reads();
      // aging
      age_sweep(32'hFFFF_FFFF);
      last_inv_reads();
      age_sweep(32'h0);
      last_inv_reads();
      check_sequence(a_addr, e_addr, 2'd0); // a floods and c left no entry behind
      check_sequence(a_addr, e_addr, 2'd0); // same again
      push_step(step_time, alut_pkg::al_cur_time, 32'h0);
      push_step(step_time, alut_pkg::al_cur_time, 32'h0);
   endtask

   // ------------------------------------------------------------
   // apb transfers with inputs moving 1 ns after the edge
   // ------------------------------------------------------------
   task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
      @(posedge pclk14);
      #1;
      psel    = 1'b1; // setup
      pwrite  = 1'b1;
      penable = 1'b0;
      paddr   = addr;
      pwdata  = data;
      @(posedge pclk14);
      #1;
      penable = 1'b1; // access
      @(posedge pclk14);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic read_reg(input logic [6:0] addr, output logic [31:0] data);
      @(posedge pclk14);
      #1;
      psel    = 1'b1;
      pwrite  = 1'b0;
      penable = 1'b0;
      paddr   = addr;
      @(posedge pclk14); // prdata registered here
      #1;
      penable = 1'b1;
      data    = prdata; // stable through access phase
      @(posedge pclk14);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // watchdog
   initial
   begin : watchdog
      while (cycle_count <= cycle_limit)
      begin
         @(posedge pclk14);
         cycle_count++;
      end
      $display("timeout after %0d cycles, the DUT stopped responding", cycle_count);
      $display("Verification failed");
      $finish;
   end

   initial
   begin : main
      logic [31:0] got;
      logic [31:0] prev_time;
      bit          time_seen;
      pclk14      = 1'b0;
      n_p_reset14 = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      prev_time   = '0;
      time_seen   = 1'b0;
      build_steps();
      cycle_limit = cycle_budget + 50; // margin for reset and slack
      repeat (2) @(posedge pclk14);
      #1;
      n_p_reset14 = 1'b1;
      for (int i = 0; i < step_kind.size(); i++)
         case (step_kind[i])
            step_write :
               write_reg(step_addr[i], step_data[i]);
            step_read :
            begin
               read_reg(step_addr[i], got);
               checks++;
               assert (got == step_data[i])
               else
               begin
                  read_errors++;
                  $display("Error at %0.2f ns: read of 0x%02h gave %08h, expected %08h",
                           $realtime, step_addr[i], got, step_data[i]);
               end
            end
            step_poll :
            begin
               read_reg(alut_pkg::al_status, got);
               while ((got & 32'h3) != 32'h0) // active or sweep still running
                  read_reg(alut_pkg::al_status, got);
               checks++;
               assert (got == step_data[i])
               else
               begin
                  status_errors++;
                  $display("Error at %0.2f ns: idle status %08h, expected %08h",
                           $realtime, got, step_data[i]);
               end
            end
            default :
            begin
               read_reg(alut_pkg::al_cur_time, got);
               if (time_seen)
               begin
                  checks++;
                  assert (got > prev_time)
                  else
                  begin
                     read_errors++;
                     $display("Error at %0.2f ns: cur_time %08h not above %08h",
                              $realtime, got, prev_time);
                  end
               end
               prev_time = got;
               time_seen = 1'b1;
            end
         endcase
      $display("checks %0d, read errors %0d, status errors %0d",
               checks, read_errors, status_errors);
      if (read_errors + status_errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

/* build.f */
logic/alut_pkg.sv
logic/alut_mem_if.sv
logic/alut_reg_bank.sv
logic/alut_addr_checker.sv
logic/alut_age_checker.sv
logic/alut_mem.sv
logic/alut.sv
verification/alut_tb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module alut_tb -Mdir obj_dir -o alut_tb

run: compile
	./obj_dir/alut_tb | tee sim.log
	grep -q "^Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
